// ==== Bender.yml ====
package:
  name: ecc_mem

sources:
  - common/ecc_pkg.sv
  - verilog/ecc_sram.sv
  - ecc/ecc_merge_enc.sv
  - ecc/ecc_dec_fix.sv
  - wb_ctrl/ecc_wb_ctrl.sv
  - verilog/ecc_mem_top.sv
  - target: test
    files:
      - dv/ecc_mem_checker.sv
      - dv/ecc_mem_monitor.sv
      - dv/ecc_mem_tb.sv

// ==== common/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

  localparam int unsigned data_width     = 64;
  localparam int unsigned ecc_width      = 8;
  localparam int unsigned code_width     = data_width + ecc_width;
  localparam int unsigned sel_width      = data_width / 8;
  localparam int unsigned mem_addr_width = 8;
  // top address bit selects the register space
  localparam int unsigned wb_addr_width  = mem_addr_width + 1;
  localparam int unsigned cnt_width      = 16;

  localparam logic [mem_addr_width-1:0] csr_inject     = 8'd0;
  localparam logic [mem_addr_width-1:0] csr_corr_cnt   = 8'd1;
  localparam logic [mem_addr_width-1:0] csr_uncorr_cnt = 8'd2;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [wb_addr_width-1:0] adr;
    logic [sel_width-1:0]     sel;
    logic [data_width-1:0]    dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic [data_width-1:0] dat;
  } wb_rsp_t;

  // data sits above the check bits, so bit k of the word is column k of h_rows
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [ecc_width-1:0]  chk;
  } code_word_t;

  typedef struct packed {
    logic                          en0;
    logic [$clog2(code_width)-1:0] pos0;
    logic                          en1;
    logic [$clog2(code_width)-1:0] pos1;
  } inject_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  corrected;
    logic                  uncorrectable;
  } dec_result_t;

  typedef enum logic [3:0] {
    idle,
    rd_wait,
    rd_fix,
    rd_done,
    rmw_wait,
    rmw_fix,
    wr_enc,
    wr_store,
    csr_resp
  } ctrl_state_e;

  // check columns are unit vectors, data columns take all weight-3 codes
  // and then the first weight-5 codes until all 64 are placed
  function automatic logic [ecc_width-1:0][code_width-1:0] gen_h_rows();
    logic [ecc_width-1:0][code_width-1:0] rows;
    int col;
    int ones;
    rows = '0;
    col  = ecc_width;
    for (int k = 0; k < ecc_width; k++) begin
      rows[k][k] = 1'b1;
    end
    for (int w = 3; w <= 5; w += 2) begin
      for (int v = 1; v < 2**ecc_width; v++) begin
        ones = 0;
        for (int b = 0; b < ecc_width; b++) begin
          ones += v[b];
        end
        if (ones == w && col < code_width) begin
          for (int r = 0; r < ecc_width; r++) begin
            rows[r][col] = v[r];
          end
          col++;
        end
      end
    end
    return rows;
  endfunction

  localparam logic [ecc_width-1:0][code_width-1:0] h_rows = gen_h_rows();

endpackage

`default_nettype wire

// ==== dv/ecc_mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_checker (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire ecc_pkg::wb_req_t  wb_req,
  input  wire ecc_pkg::wb_rsp_t  wb_rsp
);

  int fails;

  initial begin
    fails = 0;
  end

  a_ack_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(wb_rsp.ack && wb_rsp.err))
    else begin
      $error("ack and err high in the same cycle");
      fails++;
    end

  a_rsp_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_rsp.ack || wb_rsp.err) |-> (wb_req.cyc && wb_req.stb))
    else begin
      $error("response given without cyc and stb");
      fails++;
    end

  // responses stay quiet in reset and on the first cycle out of it
  a_quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !(wb_rsp.ack || wb_rsp.err))
    else begin
      $error("response while reset is active");
      fails++;
    end

  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !(wb_rsp.ack || wb_rsp.err))
    else begin
      $error("response on the first cycle after reset");
      fails++;
    end

endmodule

bind ecc_mem_top ecc_mem_checker u_checker (
  .clk    (clk),
  .arst_n (arst_n),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp)
);

`default_nettype wire

// ==== dv/ecc_mem_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_monitor (
  input  wire logic                            clk,
  input  wire logic                            arst_n,
  input  wire ecc_pkg::wb_req_t                wb_req,
  input  wire ecc_pkg::wb_rsp_t                wb_rsp,
  input  wire logic                            exp_err,
  input  wire logic [ecc_pkg::data_width-1:0]  exp_dat,
  input  wire logic                            exp_chk,
  output int                                   errors
);

  import ecc_pkg::*;

  logic [1:0] exp_outcome;
  logic [1:0] act_outcome;

  initial begin
    errors = 0;
  end

  // values are taken just before the edge, the access ends on this cycle
  always @(posedge clk) begin
    if (arst_n && wb_req.cyc && wb_req.stb && (wb_rsp.ack || wb_rsp.err)) begin
      exp_outcome = {!exp_err, exp_err};
      act_outcome = {wb_rsp.ack, wb_rsp.err};
      if (act_outcome !== exp_outcome) begin
        $display("MISMATCH t=%0t wb_rsp.ack/err expected %b actual %b (adr %h we %b)",
                 $time, exp_outcome, act_outcome, wb_req.adr, wb_req.we);
        errors++;
      end
      // read data only means something on an ack
      if (wb_rsp.ack && exp_chk && (wb_rsp.dat !== exp_dat)) begin
        $display("MISMATCH t=%0t wb_rsp.dat expected %h actual %h (adr %h)",
                 $time, exp_dat, wb_rsp.dat, wb_req.adr);
        errors++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/ecc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;

  import ecc_pkg::*;

  localparam int timeout_cycles = 50;
  localparam int mix_addrs      = 16;
  localparam int mix_steps      = 400;

  logic                  clk;
  logic                  arst_n;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  logic                  exp_err;
  logic [data_width-1:0] exp_dat;
  logic                  exp_chk;
  int                    mon_errors;
  int                    tb_errors;
  logic [31:0]           seed;

  // reference memory and the number of flipped bits stored in each word
  logic [data_width-1:0] model_mem [2**mem_addr_width];
  int                    model_flips [2**mem_addr_width];
  int                    model_corr;
  int                    model_uncorr;
  inject_t               pend_inj;
  int                    pend_flips;

  ecc_mem_top u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  ecc_mem_monitor u_mon (
    .clk     (clk),
    .arst_n  (arst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .exp_err (exp_err),
    .exp_dat (exp_dat),
    .exp_chk (exp_chk),
    .errors  (mon_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [data_width-1:0] rand64();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic logic [sel_width-1:0] rand_sel();
    logic [sel_width-1:0] s;
    s = sel_width'(lcg_next() >> 8);
    if (s == '1) begin
      s = 8'h7e;
    end
    return s;
  endfunction

  task automatic wb_access(input logic we, input logic [wb_addr_width-1:0] adr,
                           input logic [sel_width-1:0] sel,
                           input logic [data_width-1:0] dat, input logic e_err,
                           input logic [data_width-1:0] e_dat, input logic e_chk);
    int   waited;
    logic got;
    @(negedge clk);
    exp_err    = e_err;
    exp_dat    = e_dat;
    exp_chk    = e_chk;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.sel = sel;
    wb_req.dat = dat;
    waited     = 0;
    got        = 1'b0;
    while (!got && waited < timeout_cycles) begin
      @(posedge clk);
      got = wb_rsp.ack || wb_rsp.err;
      waited++;
    end
    if (!got) begin
      $display("timeout: address %h got neither ack nor err in %0d cycles", adr, waited);
      tb_errors++;
    end
    @(negedge clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic mem_read(input int a);
    int f;
    f = model_flips[a];
    if (f == 1) begin
      model_corr++;
    end else if (f >= 2) begin
      model_uncorr++;
    end
    wb_access(1'b0, wb_addr_width'(a), '1, '0, f >= 2, model_mem[a], f < 2);
  endtask

  // a partial write decodes the old word first and aborts on a double error
  task automatic mem_write(input int a, input logic [sel_width-1:0] sel,
                           input logic [data_width-1:0] d);
    logic partial;
    logic abort;
    partial = (sel != '1);
    abort   = partial && (model_flips[a] >= 2);
    if (partial && model_flips[a] == 1) begin
      model_corr++;
    end
    if (abort) begin
      model_uncorr++;
    end
    wb_access(1'b1, wb_addr_width'(a), sel, d, abort, '0, 1'b0);
    if (!abort) begin
      for (int b = 0; b < sel_width; b++) begin
        if (sel[b]) begin
          model_mem[a][b*8 +: 8] = d[b*8 +: 8];
        end
      end
      model_flips[a] = pend_flips;
      pend_flips     = 0;
      pend_inj       = '0;
    end
  endtask

  task automatic set_inject(input int n);
    inject_t inj;
    inj      = '0;
    inj.en0  = 1'b1;
    inj.pos0 = 7'(lcg_next() % code_width);
    if (n == 2) begin
      inj.en1  = 1'b1;
      inj.pos1 = 7'((inj.pos0 + 1 + lcg_next() % (code_width - 1)) % code_width);
    end
    wb_access(1'b1, {1'b1, csr_inject}, '1, 64'(inj), 1'b0, '0, 1'b0);
    pend_inj   = inj;
    pend_flips = n;
  endtask

  task automatic check_regs();
    wb_access(1'b0, {1'b1, csr_inject}, '1, '0, 1'b0, 64'(pend_inj), 1'b1);
    wb_access(1'b0, {1'b1, csr_corr_cnt}, '1, '0, 1'b0, 64'(model_corr), 1'b1);
    wb_access(1'b0, {1'b1, csr_uncorr_cnt}, '1, '0, 1'b0, 64'(model_uncorr), 1'b1);
  endtask

  initial begin
    int a;
    int op;
    seed         = 32'he62b;
    tb_errors    = 0;
    model_corr   = 0;
    model_uncorr = 0;
    pend_inj     = '0;
    pend_flips   = 0;
    wb_req       = '0;
    exp_err      = 1'b0;
    exp_dat      = '0;
    exp_chk      = 1'b0;
    arst_n       = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    check_regs();
    // fill every word so no read sees an unwritten entry
    for (int w = 0; w < 2**mem_addr_width; w++) begin
      model_flips[w] = 0;
      mem_write(w, '1, rand64());
    end
    for (int w = 0; w < 2**mem_addr_width; w++) begin
      mem_read(w);
    end
    // small address window so injected words get revisited
    for (int i = 0; i < mix_steps; i++) begin
      a  = int'(lcg_next() % mix_addrs);
      op = int'(lcg_next() % 8);
      if (op < 3) begin
        mem_read(a);
      end else if (op < 5) begin
        mem_write(a, '1, rand64());
      end else if (op < 7) begin
        mem_write(a, rand_sel(), rand64());
      end else begin
        set_inject(1 + int'(lcg_next() % 2));
        mem_write(a, (lcg_next() % 2 == 0) ? '1 : rand_sel(), rand64());
      end
      if (i % 25 == 24) begin
        check_regs();
      end
    end
    // double error stays until a full write repairs the word
    set_inject(2);
    mem_write(40, '1, rand64());
    mem_read(40);
    mem_write(40, 8'h0f, rand64());
    mem_read(40);
    mem_write(40, '1, rand64());
    mem_read(40);
    // inject covers one store only
    set_inject(1);
    mem_write(41, '1, rand64());
    check_regs();
    mem_write(42, '1, rand64());
    mem_read(41);
    mem_read(42);
    check_regs();
    repeat (2) @(negedge clk);
    $display("mismatches %0d, timeouts %0d, assertion failures %0d",
             mon_errors, tb_errors, u_dut.u_checker.fails);
    if (mon_errors + tb_errors + u_dut.u_checker.fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ecc/ecc_dec_fix.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_dec_fix (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              dec_go,
  input  ecc_pkg::code_word_t    code_in,
  output ecc_pkg::dec_result_t   result
);

  import ecc_pkg::*;

  logic [ecc_width-1:0]  syndrome;
  logic [code_width-1:0] flip;
  logic                  corr;
  logic                  uncorr;
  code_word_t            fixed;

  always_comb begin
    for (int k = 0; k < ecc_width; k++) begin
      syndrome[k] = ^(code_in & h_rows[k]);
    end
  end

  // look for the column equal to the syndrome
  always_comb begin
    logic match;
    flip = '0;
    for (int j = 0; j < code_width; j++) begin
      match = 1'b1;
      for (int k = 0; k < ecc_width; k++) begin
        if (h_rows[k][j] != syndrome[k]) begin
          match = 1'b0;
        end
      end
      flip[j] = match && (syndrome != '0);
    end
  end

  // even weight or an unused odd code means more than one bit is wrong
  assign corr   = (^syndrome) && (|flip);
  assign uncorr = (syndrome != '0) && !corr;
  assign fixed  = code_in ^ flip;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (dec_go) begin
      result.data          <= fixed.data;
      result.corrected     <= corr;
      result.uncorrectable <= uncorr;
    end
  end

endmodule

`default_nettype wire

// ==== ecc/ecc_merge_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_merge_enc (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             enc_go,
  input  wire logic [ecc_pkg::data_width-1:0]   wr_data,
  input  wire logic [ecc_pkg::sel_width-1:0]    wr_sel,
  input  wire logic [ecc_pkg::data_width-1:0]   rd_merge_data,
  input  ecc_pkg::inject_t                      inject,
  output ecc_pkg::code_word_t                   code_out
);

  import ecc_pkg::*;

  logic [data_width-1:0] merged;
  logic [code_width-1:0] flip_mask;
  code_word_t            enc_word;

  // selected bytes come from the new data, the rest from the old word
  for (genvar i = 0; i < sel_width; i++) begin : g_merge
    assign merged[i*8 +: 8] = wr_sel[i] ? wr_data[i*8 +: 8] : rd_merge_data[i*8 +: 8];
  end

  always_comb begin
    enc_word.data = merged;
    for (int k = 0; k < ecc_width; k++) begin
      enc_word.chk[k] = ^(merged & h_rows[k][code_width-1:ecc_width]);
    end
  end

  // diagnostic flips are applied after the check bits are formed
  always_comb begin
    flip_mask = '0;
    if (inject.en0) begin
      flip_mask[inject.pos0] = 1'b1;
    end
    if (inject.en1) begin
      flip_mask[inject.pos1] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      code_out <= '0;
    end else if (enc_go) begin
      code_out <= enc_word ^ flip_mask;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/ecc_pkg.sv
verilog/ecc_sram.sv
ecc/ecc_merge_enc.sv
ecc/ecc_dec_fix.sv
wb_ctrl/ecc_wb_ctrl.sv
verilog/ecc_mem_top.sv
dv/ecc_mem_checker.sv
dv/ecc_mem_monitor.sv
dv/ecc_mem_tb.sv

// ==== verilog/ecc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top (
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  ecc_pkg::wb_req_t   wb_req,
  output ecc_pkg::wb_rsp_t   wb_rsp
);

  import ecc_pkg::*;

  logic                       enc_go;
  logic [data_width-1:0]      enc_new;
  logic [sel_width-1:0]       enc_sel;
  logic [data_width-1:0]      enc_old;
  inject_t                    enc_inject;
  code_word_t                 enc_word;
  logic                       mem_en;
  logic                       mem_we;
  logic [mem_addr_width-1:0]  mem_idx;
  code_word_t                 mem_wdata;
  code_word_t                 mem_rdata;
  logic                       dec_go;
  dec_result_t                dec_res;

  ecc_wb_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .enc_go     (enc_go),
    .enc_new    (enc_new),
    .enc_sel    (enc_sel),
    .enc_old    (enc_old),
    .enc_inject (enc_inject),
    .enc_word   (enc_word),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_idx    (mem_idx),
    .mem_wdata  (mem_wdata),
    .dec_go     (dec_go),
    .dec_res    (dec_res)
  );

  ecc_merge_enc u_enc (
    .clk           (clk),
    .arst_n        (arst_n),
    .enc_go        (enc_go),
    .wr_data       (enc_new),
    .wr_sel        (enc_sel),
    .rd_merge_data (enc_old),
    .inject        (enc_inject),
    .code_out      (enc_word)
  );

  ecc_dec_fix u_dec (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec_go  (dec_go),
    .code_in (mem_rdata),
    .result  (dec_res)
  );

  ecc_sram u_mem (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .idx   (mem_idx),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/ecc_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_sram (
  input  wire logic                                clk,
  input  wire logic                                en,
  input  wire logic                                we,
  input  wire logic [ecc_pkg::mem_addr_width-1:0]  idx,
  input  ecc_pkg::code_word_t                      wdata,
  output ecc_pkg::code_word_t                      rdata
);

  import ecc_pkg::*;

  code_word_t mem [2**mem_addr_width];

  // a write does not update the read register
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[idx] <= wdata;
      end else begin
        rdata <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== wb_ctrl/ecc_wb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_wb_ctrl (
  input  wire logic                                clk,
  input  wire logic                                arst_n,
  input  ecc_pkg::wb_req_t                         wb_req,
  output ecc_pkg::wb_rsp_t                         wb_rsp,
  output logic                                     enc_go,
  output logic [ecc_pkg::data_width-1:0]           enc_new,
  output logic [ecc_pkg::sel_width-1:0]            enc_sel,
  output logic [ecc_pkg::data_width-1:0]           enc_old,
  output ecc_pkg::inject_t                         enc_inject,
  input  ecc_pkg::code_word_t                      enc_word,
  output logic                                     mem_en,
  output logic                                     mem_we,
  output logic [ecc_pkg::mem_addr_width-1:0]       mem_idx,
  output ecc_pkg::code_word_t                      mem_wdata,
  output logic                                     dec_go,
  input  ecc_pkg::dec_result_t                     dec_res
);

  import ecc_pkg::*;

  ctrl_state_e            state_q;
  ctrl_state_e            state_d;
  inject_t                inject_q;
  logic [cnt_width-1:0]   corr_cnt;
  logic [cnt_width-1:0]   uncorr_cnt;
  logic [data_width-1:0]  csr_rdata;
  logic                   is_csr;
  logic                   partial;
  logic                   rmw_abort;
  logic                   dec_sample;

  // request fields stay stable until ack or err
  assign is_csr  = wb_req.adr[wb_addr_width-1];
  assign partial = (wb_req.sel != '1);

  // old word of a read-modify-write cannot be trusted
  assign rmw_abort  = (state_q == wr_enc) && partial && dec_res.uncorrectable;
  assign dec_sample = (state_q == rd_done) || ((state_q == wr_enc) && partial);

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (wb_req.cyc && wb_req.stb) begin
          if (is_csr) begin
            state_d = csr_resp;
          end else if (!wb_req.we) begin
            state_d = rd_wait;
          end else if (partial) begin
            state_d = rmw_wait;
          end else begin
            state_d = wr_enc;
          end
        end
      end
      rd_wait:  state_d = rd_fix;
      rd_fix:   state_d = rd_done;
      rmw_wait: state_d = rmw_fix;
      rmw_fix:  state_d = wr_enc;
      wr_enc:   state_d = rmw_abort ? idle : wr_store;
      default:  state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    csr_rdata = '0;
    case (wb_req.adr[mem_addr_width-1:0])
      csr_inject:     csr_rdata[$bits(inject_t)-1:0] = inject_q;
      csr_corr_cnt:   csr_rdata[cnt_width-1:0]       = corr_cnt;
      csr_uncorr_cnt: csr_rdata[cnt_width-1:0]       = uncorr_cnt;
      default:        csr_rdata = '0;
    endcase
  end

  // inject is one-shot, counters saturate
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inject_q   <= '0;
      corr_cnt   <= '0;
      uncorr_cnt <= '0;
    end else begin
      if (state_q == csr_resp && wb_req.we &&
          wb_req.adr[mem_addr_width-1:0] == csr_inject) begin
        inject_q <= inject_t'(wb_req.dat[$bits(inject_t)-1:0]);
      end else if (state_q == wr_store) begin
        inject_q <= '0;
      end
      if (dec_sample && dec_res.corrected && corr_cnt != '1) begin
        corr_cnt <= corr_cnt + 1'b1;
      end
      if (dec_sample && dec_res.uncorrectable && uncorr_cnt != '1) begin
        uncorr_cnt <= uncorr_cnt + 1'b1;
      end
    end
  end

  assign enc_go     = (state_q == wr_enc) && !rmw_abort;
  assign enc_new    = wb_req.dat;
  assign enc_sel    = wb_req.sel;
  assign enc_old    = dec_res.data;
  assign enc_inject = inject_q;

  assign mem_en    = (state_q == rd_wait) || (state_q == rmw_wait) || (state_q == wr_store);
  assign mem_we    = (state_q == wr_store);
  assign mem_idx   = wb_req.adr[mem_addr_width-1:0];
  assign mem_wdata = enc_word;
  assign dec_go    = (state_q == rd_fix) || (state_q == rmw_fix);

  assign wb_rsp.ack = (state_q == csr_resp) || (state_q == wr_store) ||
                      ((state_q == rd_done) && !dec_res.uncorrectable);
  assign wb_rsp.err = ((state_q == rd_done) && dec_res.uncorrectable) || rmw_abort;
  assign wb_rsp.dat = (state_q == csr_resp) ? csr_rdata : dec_res.data;

endmodule

`default_nettype wire
